/* common/vcu_settings.svh */
// global sizes for the vector control unit; VLEN must be a power of two and at least 256
`ifndef VCU_SETTINGS_SVH
`define VCU_SETTINGS_SVH

// vector register length in bits
`define VCU_VLEN 4096

// lane count of the datapath
`define VCU_LANES 16

// number of write-port groups
`define VCU_WPORTS 4

// min cycles a port keeps its vd record after a start
`define VCU_DEP_DELAY 11

`endif

/* common/vcu_cfg_pkg.sv */
// vtype layout follows the 32-bit vtype CSR; lmul code 4 is reserved and never yields a valid VLMAX
package vcu_cfg_pkg;
`include "vcu_settings.svh"

   typedef logic [2:0] sew_t;   // element width, 8 << sew bits
   typedef logic [2:0] lmul_t;  // 0..3 multiply, 5..7 fractional

   typedef struct packed {
      logic        vill;
      logic [22:0] rsvd;
      logic        vma;
      logic        vta;
      sew_t        sew;
      lmul_t       lmul;
   } vtype_t;

   localparam logic [31:0] VL_RESET = `VCU_VLEN / 32;

   // elements per register group
   function automatic logic [31:0] vlmax_f(lmul_t lmul, sew_t sew);
      logic [31:0] base;
      base = (`VCU_VLEN / 8) >> sew;
      if (lmul[2])
         return base >> (4'd8 - {1'b0, lmul});  // fractional group
      else
         return base << lmul;
   endfunction

endpackage

/* common/vcu_op_pkg.sv */
// operation encodings shared by decode and issue; alu opcodes are local to this design
package vcu_op_pkg;
`include "vcu_settings.svh"

   // class as reported by the scalar scheduler
   typedef enum logic [2:0] {
      CLS_CONFIG = 3'd0,
      CLS_OPIVV  = 3'd1,
      CLS_OPIVX  = 3'd2,
      CLS_OPIVI  = 3'd3,
      CLS_OPMVV  = 3'd4,
      CLS_OPMVX  = 3'd5,
      CLS_LOAD   = 3'd6,
      CLS_STORE  = 3'd7
   } instr_class_e;

   typedef enum logic [2:0] {
      IT_NORMAL = 3'd0,
      IT_STORE  = 3'd2,
      IT_LOAD   = 3'd4
   } inst_type_e;

   typedef enum logic [1:0] {
      OP2_VECTOR = 2'd0,
      OP2_SCALAR = 2'd1,
      OP2_IMM    = 2'd2,
      OP2_NONE   = 2'd3
   } op2_sel_e;

   typedef enum logic [8:0] {
      ALU_NOP     = 9'd0,
      ALU_ADD     = 9'd1,
      ALU_SUB     = 9'd2,
      ALU_AND     = 9'd3,
      ALU_OR      = 9'd4,
      ALU_XOR     = 9'd5,
      ALU_SLL     = 9'd6,
      ALU_SRL     = 9'd7,
      ALU_SRA     = 9'd8,
      ALU_MUL     = 9'd9,
      ALU_MULH    = 9'd10,
      ALU_MUL_ADD = 9'd11
   } alu_op_e;

   typedef logic [4:0] vreg_t;
   typedef logic [`VCU_WPORTS-1:0] port_mask_t;  // one bit per write-port group

endpackage

/* common/decode_if.sv */
// decoded instruction held by the decoder; fields are stable until the next acceptance
`timescale 1ns/1ps

interface decode_if;
   import vcu_op_pkg::*;

   inst_type_e  inst_type;
   op2_sel_e    op2_sel;
   alu_op_e     alu_op;
   vreg_t       vs1;
   vreg_t       vs2;
   vreg_t       vd;
   logic        reads_vs1;
   logic        reads_vs2;
   logic        reads_vd;
   logic        writes_vd;
   logic        vector_mask;
   logic [4:0]  imm;
   logic [31:0] x_data;

   modport src (output inst_type, op2_sel, alu_op, vs1, vs2, vd, reads_vs1, reads_vs2,
                reads_vd, writes_vd, vector_mask, imm, x_data);
   // hazard side only needs the register fields
   modport chk (input vs1, vs2, vd, reads_vs1, reads_vs2, reads_vd, writes_vd);
endinterface

/* config/vtype_config.sv */
// immediate form takes lmul from bits {25,21:20} and sew from 24:22; lmul code 4 must not be written
`timescale 1ns/1ps

module vtype_config (
   input  logic               clk,
   input  logic               rstn,
   input  logic               cfg_write_i,
   input  logic [31:0]        instr_i,
   input  logic [31:0]        scalar_rs1_i,
   output vcu_cfg_pkg::sew_t  sew_o,
   output vcu_cfg_pkg::lmul_t lmul_o,
   output logic [31:0]        vl_o
);
   import vcu_cfg_pkg::*;

   vtype_t      vtype_q;
   vtype_t      vtype_next;
   logic [31:0] vl_q;
   logic [31:0] vl_next;

   always_comb
   begin
      vtype_next = '0;
      if (instr_i[31:30] == 2'b10)
         vtype_next = vtype_t'(scalar_rs1_i);  // vsetvl, vtype from rs1 value
      else
      begin
         vtype_next.lmul = {instr_i[25], instr_i[21:20]};
         vtype_next.sew  = instr_i[24:22];
         vtype_next.vta  = instr_i[26];
         vtype_next.vma  = instr_i[27];
      end
   end

   // rs1 field wins, then rd field asks for vlmax
   assign vl_next = (instr_i[19:15] != 5'd0) ? scalar_rs1_i :
                    (instr_i[11:7] != 5'd0)  ? vlmax_f(vtype_next.lmul, vtype_next.sew) :
                    vl_q;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_q <= '{vill: 1'b0, rsvd: '0, vma: 1'b0, vta: 1'b0, sew: 3'd2, lmul: 3'd0};
         vl_q    <= VL_RESET;
      end
      else if (cfg_write_i)
      begin
         vtype_q <= vtype_next;
         vl_q    <= vl_next;
      end
   end

   assign sew_o  = vtype_q.sew;
   assign lmul_o = vtype_q.lmul;
   assign vl_o   = vl_q;

   a_lmul_legal: assert property (@(posedge clk) disable iff (!rstn)
      cfg_write_i |=> vtype_q.lmul != 3'd4);
endmodule

/* decode/instr_decoder.sv */
// decodes only the reduced funct6 table; unlisted codes and non-arithmetic classes give nop
`timescale 1ns/1ps

module instr_decoder (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     load_i,
   input  vcu_op_pkg::instr_class_e class_i,
   input  logic [31:0]              instr_i,
   input  logic [31:0]              scalar_rs1_i,
   decode_if.src                    dec
);
   import vcu_op_pkg::*;

   instr_class_e class_q;
   logic [31:0]  instr_q;
   logic [31:0]  rs1_q;
   logic [5:0]   funct6;
   logic         arith;

   // config class after reset means nothing is read or written
   always_ff @(posedge clk)
   begin
      if (!rstn)
         class_q <= CLS_CONFIG;
      else if (load_i)
         class_q <= class_i;
   end

   always_ff @(posedge clk)
   begin
      if (load_i)
      begin
         instr_q <= instr_i;
         rs1_q   <= scalar_rs1_i;
      end
   end

   assign funct6 = instr_q[31:26];
   assign arith  = class_q inside {CLS_OPIVV, CLS_OPIVX, CLS_OPIVI, CLS_OPMVV, CLS_OPMVX};

   always_comb
   begin
      dec.alu_op = ALU_NOP;
      case (class_q)
         CLS_OPIVV, CLS_OPIVX, CLS_OPIVI:
            case (funct6)
               6'b000000: dec.alu_op = ALU_ADD;
               6'b000010: dec.alu_op = ALU_SUB;
               6'b001001: dec.alu_op = ALU_AND;
               6'b001010: dec.alu_op = ALU_OR;
               6'b001011: dec.alu_op = ALU_XOR;
               6'b100101: dec.alu_op = ALU_SLL;
               6'b101000: dec.alu_op = ALU_SRL;
               6'b101001: dec.alu_op = ALU_SRA;
               default:   dec.alu_op = ALU_NOP;
            endcase
         CLS_OPMVV, CLS_OPMVX:
            case (funct6)
               6'b100101: dec.alu_op = ALU_MUL;
               6'b100111: dec.alu_op = ALU_MULH;
               6'b101101: dec.alu_op = ALU_MUL_ADD;  // vmacc
               default:   dec.alu_op = ALU_NOP;
            endcase
         default: dec.alu_op = ALU_NOP;
      endcase
   end

   always_comb
   begin
      case (class_q)
         CLS_OPIVV, CLS_OPMVV: dec.op2_sel = OP2_VECTOR;
         CLS_OPIVX, CLS_OPMVX: dec.op2_sel = OP2_SCALAR;
         CLS_OPIVI:            dec.op2_sel = OP2_IMM;
         default:              dec.op2_sel = OP2_NONE;
      endcase
   end

   assign dec.inst_type   = (class_q == CLS_LOAD)  ? IT_LOAD :
                            (class_q == CLS_STORE) ? IT_STORE : IT_NORMAL;
   assign dec.reads_vs1   = class_q inside {CLS_OPIVV, CLS_OPMVV};
   assign dec.reads_vs2   = arith;
   assign dec.reads_vd    = (class_q == CLS_STORE);  // store data lives in vd
   assign dec.writes_vd   = arith || (class_q == CLS_LOAD);
   assign dec.vs1         = instr_q[19:15];
   assign dec.vs2         = instr_q[24:20];
   assign dec.vd          = instr_q[11:7];
   assign dec.imm         = instr_q[19:15];
   assign dec.x_data      = rs1_q;
   assign dec.vector_mask = ~instr_q[25];
endmodule

/* issue/dep_timer.sv */
// counters reload on start and stop at zero; a port is expired from reset on
`timescale 1ns/1ps
`include "vcu_settings.svh"

module dep_timer (
   input  logic                   clk,
   input  logic                   rstn,
   input  vcu_op_pkg::port_mask_t load_i,
   output vcu_op_pkg::port_mask_t expired_o
);
   localparam int CNT_W = $clog2(`VCU_DEP_DELAY + 1);

   logic [CNT_W-1:0] cnt_q [`VCU_WPORTS];

   always_ff @(posedge clk)
   begin
      for (int p = 0; p < `VCU_WPORTS; p++)
      begin
         if (!rstn)
            cnt_q[p] <= '0;
         else if (load_i[p])
            cnt_q[p] <= CNT_W'(`VCU_DEP_DELAY);
         else if (cnt_q[p] != '0)
            cnt_q[p] <= cnt_q[p] - 1'b1;
      end
   end

   always_comb
   begin
      for (int p = 0; p < `VCU_WPORTS; p++)
         expired_o[p] = (cnt_q[p] == '0);
   end
endmodule

/* issue/port_tracker.sv */
// a port stays busy until done is seen and its dependency timer has run out
`timescale 1ns/1ps
`include "vcu_settings.svh"

module port_tracker (
   input  logic                   clk,
   input  logic                   rstn,
   decode_if.chk                  dec,
   input  vcu_op_pkg::port_mask_t start_i,
   input  vcu_op_pkg::port_mask_t port_done_i,
   output logic                   can_issue_o,
   output vcu_op_pkg::port_mask_t free_port_o
);
   import vcu_op_pkg::*;

   port_mask_t busy;
   port_mask_t done_seen;
   port_mask_t wr_rec;   // port writes its vd
   port_mask_t expired;
   port_mask_t hazard;
   port_mask_t avail;
   vreg_t      vd_rec [`VCU_WPORTS];

   dep_timer dep_timer_inst (
      .clk       (clk),
      .rstn      (rstn),
      .load_i    (start_i),
      .expired_o (expired)
   );

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         busy      <= '0;
         done_seen <= '0;
      end
      else
      begin
         for (int p = 0; p < `VCU_WPORTS; p++)
         begin
            if (start_i[p])
            begin
               busy[p]      <= 1'b1;
               done_seen[p] <= 1'b0;
            end
            else if (busy[p] && (done_seen[p] || port_done_i[p]) && expired[p])
            begin
               busy[p]      <= 1'b0;
               done_seen[p] <= 1'b0;
            end
            else if (busy[p] && port_done_i[p])
               done_seen[p] <= 1'b1;  // wait for the timer
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int p = 0; p < `VCU_WPORTS; p++)
      begin
         if (start_i[p])
         begin
            vd_rec[p] <= dec.vd;
            wr_rec[p] <= dec.writes_vd;
         end
      end
   end

   always_comb
   begin
      for (int p = 0; p < `VCU_WPORTS; p++)
         hazard[p] = busy[p] && wr_rec[p] &&
                     ((dec.reads_vs1 && (vd_rec[p] == dec.vs1)) ||
                      (dec.reads_vs2 && (vd_rec[p] == dec.vs2)) ||
                      (dec.reads_vd  && (vd_rec[p] == dec.vd)));
   end

   assign avail       = ~busy;
   assign free_port_o = avail & (~avail + 1'b1);  // lowest free port
   assign can_issue_o = (hazard == '0) && (avail != '0);

   a_start_free: assert property (@(posedge clk) disable iff (!rstn) (start_i & busy) == '0);
endmodule

/* issue/issue_fsm.sv */
// config completes at acceptance; any other class holds ready low until its start pulse
`timescale 1ns/1ps

module issue_fsm (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     instr_valid_i,
   input  vcu_op_pkg::instr_class_e class_i,
   input  logic                     can_issue_i,
   input  vcu_op_pkg::port_mask_t   free_port_i,
   output logic                     instr_ready_o,
   output logic                     cfg_write_o,
   output logic                     load_o,
   output vcu_op_pkg::port_mask_t   start_o
);
   import vcu_op_pkg::*;

   typedef enum logic {IDLE, PENDING} state_t;

   state_t state_q;
   logic   issue;
   logic   accept;

   assign issue         = (state_q == PENDING) && can_issue_i;
   assign instr_ready_o = (state_q == IDLE) || issue;  // next instr may land on the start edge
   assign accept        = instr_valid_i && instr_ready_o;
   assign cfg_write_o   = accept && (class_i == CLS_CONFIG);
   assign load_o        = accept && (class_i != CLS_CONFIG);
   assign start_o       = issue ? free_port_i : port_mask_t'('0);

   always_ff @(posedge clk)
   begin
      if (!rstn)
         state_q <= IDLE;
      else if (load_o)
         state_q <= PENDING;
      else if (issue)
         state_q <= IDLE;
   end

   a_start_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(start_o));
endmodule

/* source/vector_cu.sv */
// one instruction in flight upstream; lane outputs are valid only while start_o is nonzero
`timescale 1ns/1ps

module vector_cu (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      instr_valid_i,
   input  vcu_op_pkg::instr_class_e  instr_class_i,
   input  logic [31:0]               instr_i,
   input  logic [31:0]               scalar_rs1_i,
   input  vcu_op_pkg::port_mask_t    port_done_i,
   output logic                      instr_ready_o,
   output vcu_cfg_pkg::sew_t         sew_o,
   output vcu_cfg_pkg::lmul_t        lmul_o,
   output logic [31:0]               vl_o,
   output vcu_op_pkg::port_mask_t    start_o,
   output vcu_op_pkg::inst_type_e    inst_type_o,
   output vcu_op_pkg::op2_sel_e      op2_sel_o,
   output vcu_op_pkg::alu_op_e       alu_opmode_o,
   output logic [31:0]               alu_x_data_o,
   output logic [4:0]                alu_imm_o,
   output vcu_op_pkg::vreg_t         vd_o,
   output logic                      vector_mask_o
);
   import vcu_op_pkg::*;

   logic       cfg_write;
   logic       load;
   logic       can_issue;
   port_mask_t free_port;

   decode_if dec_if ();

   vtype_config vtype_config_inst (
      .clk          (clk),
      .rstn         (rstn),
      .cfg_write_i  (cfg_write),
      .instr_i      (instr_i),
      .scalar_rs1_i (scalar_rs1_i),
      .sew_o        (sew_o),
      .lmul_o       (lmul_o),
      .vl_o         (vl_o)
   );

   instr_decoder instr_decoder_inst (
      .clk          (clk),
      .rstn         (rstn),
      .load_i       (load),
      .class_i      (instr_class_i),
      .instr_i      (instr_i),
      .scalar_rs1_i (scalar_rs1_i),
      .dec          (dec_if.src)
   );

   issue_fsm issue_fsm_inst (
      .clk           (clk),
      .rstn          (rstn),
      .instr_valid_i (instr_valid_i),
      .class_i       (instr_class_i),
      .can_issue_i   (can_issue),
      .free_port_i   (free_port),
      .instr_ready_o (instr_ready_o),
      .cfg_write_o   (cfg_write),
      .load_o        (load),
      .start_o       (start_o)
   );

   port_tracker port_tracker_inst (
      .clk         (clk),
      .rstn        (rstn),
      .dec         (dec_if.chk),
      .start_i     (start_o),
      .port_done_i (port_done_i),
      .can_issue_o (can_issue),
      .free_port_o (free_port)
   );

   // lane-side view of the held instruction
   assign inst_type_o   = dec_if.inst_type;
   assign op2_sel_o     = dec_if.op2_sel;
   assign alu_opmode_o  = dec_if.alu_op;
   assign alu_x_data_o  = dec_if.x_data;
   assign alu_imm_o     = dec_if.imm;
   assign vd_o          = dec_if.vd;
   assign vector_mask_o = dec_if.vector_mask;
endmodule

/* tests/vector_cu_tb.sv */
// config immediates use the decoder layout (lmul in bits 25,21:20 and sew in 24:22); sew stays 0..3
`timescale 1ns/1ps
`include "vcu_settings.svh"

module vector_cu_tb;
   import vcu_cfg_pkg::*;
   import vcu_op_pkg::*;

   localparam int WP = `VCU_WPORTS;
   localparam logic [6:0] OPC_V  = 7'h57;
   localparam logic [6:0] OPC_LD = 7'h07;
   localparam logic [6:0] OPC_ST = 7'h27;

   logic         clk;
   logic         rstn;
   logic         instr_valid;
   instr_class_e instr_class;
   logic [31:0]  instr;
   logic [31:0]  scalar_rs1;
   port_mask_t   port_done;
   logic         instr_ready;
   sew_t         sew;
   lmul_t        lmul;
   logic [31:0]  vl;
   port_mask_t   start;
   inst_type_e   inst_type;
   op2_sel_e     op2_sel;
   alu_op_e      alu_opmode;
   logic [31:0]  alu_x_data;
   logic [4:0]   alu_imm;
   vreg_t        vd;
   logic         vector_mask;

   int           cyc;
   port_mask_t   busy_m;       // port model
   port_mask_t   done_m;
   port_mask_t   wr_m;
   int           start_m [WP];
   vreg_t        vd_m [WP];
   instr_class_e cur_cls;      // last instruction sent
   logic [31:0]  cur_instr;
   logic [31:0]  cur_rs1;
   logic [31:0]  exp_vl;

   vector_cu vector_cu_inst (
      .clk           (clk),
      .rstn          (rstn),
      .instr_valid_i (instr_valid),
      .instr_class_i (instr_class),
      .instr_i       (instr),
      .scalar_rs1_i  (scalar_rs1),
      .port_done_i   (port_done),
      .instr_ready_o (instr_ready),
      .sew_o         (sew),
      .lmul_o        (lmul),
      .vl_o          (vl),
      .start_o       (start),
      .inst_type_o   (inst_type),
      .op2_sel_o     (op2_sel),
      .alu_opmode_o  (alu_opmode),
      .alu_x_data_o  (alu_x_data),
      .alu_imm_o     (alu_imm),
      .vd_o          (vd),
      .vector_mask_o (vector_mask)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   function automatic bit is_arith(instr_class_e c);
      return c inside {CLS_OPIVV, CLS_OPIVX, CLS_OPIVI, CLS_OPMVV, CLS_OPMVX};
   endfunction

   // reduced funct6 table, rvv encodings
   function automatic alu_op_e exp_alu(instr_class_e c, logic [5:0] f);
      alu_op_e r;
      r = ALU_NOP;
      if (c inside {CLS_OPIVV, CLS_OPIVX, CLS_OPIVI})
         case (f)
            6'h00: r = ALU_ADD;
            6'h02: r = ALU_SUB;
            6'h09: r = ALU_AND;
            6'h0a: r = ALU_OR;
            6'h0b: r = ALU_XOR;
            6'h25: r = ALU_SLL;
            6'h28: r = ALU_SRL;
            6'h29: r = ALU_SRA;
            default: r = ALU_NOP;
         endcase
      else if (c inside {CLS_OPMVV, CLS_OPMVX})
         case (f)
            6'h25: r = ALU_MUL;
            6'h27: r = ALU_MULH;
            6'h2d: r = ALU_MUL_ADD;
            default: r = ALU_NOP;
         endcase
      return r;
   endfunction

   function automatic int unsigned exp_vlmax(lmul_t l, sew_t s);
      int unsigned base;
      base = (`VCU_VLEN / 8) / (1 << s);
      if (l >= 5)
         return base / (1 << (8 - l));  // fractional lmul
      return base * (1 << l);
   endfunction

   function automatic bit model_free(int p);
      return !busy_m[p] || (done_m[p] && (cyc - start_m[p] > `VCU_DEP_DELAY));
   endfunction

   function automatic logic [31:0] make_instr(logic [5:0] f6, logic vm, vreg_t vs2, vreg_t vs1,
                                              vreg_t vdf, logic [6:0] opc);
      return {f6, vm, vs2, vs1, 3'b000, vdf, opc};
   endfunction

   function automatic logic [31:0] make_vsetvli(sew_t s, lmul_t l, vreg_t rs1f, vreg_t rdf);
      logic [31:0] r;
      r = {6'b0, l[2], s, l[1:0], rs1f, 3'b111, rdf, OPC_V};
      return r;
   endfunction

   task automatic drive_instr(input instr_class_e cls, input logic [31:0] ins,
                              input logic [31:0] rs1);
      int t;
      @(posedge clk);
      instr_valid <= 1'b1;
      instr_class <= cls;
      instr       <= ins;
      scalar_rs1  <= rs1;
      cur_cls   = cls;
      cur_instr = ins;
      cur_rs1   = rs1;
      t = 0;
      @(negedge clk);
      while (!instr_ready)
      begin
         t++;
         if (t > 300)
            stop_run("timeout waiting for instr_ready_o");
         @(negedge clk);
      end
      @(posedge clk);  // acceptance edge
      instr_valid <= 1'b0;
   endtask

   task automatic check_decode();
      inst_type_e et;
      op2_sel_e   eo;
      et = (cur_cls == CLS_LOAD) ? IT_LOAD : (cur_cls == CLS_STORE) ? IT_STORE : IT_NORMAL;
      eo = (cur_cls inside {CLS_OPIVV, CLS_OPMVV}) ? OP2_VECTOR :
           (cur_cls inside {CLS_OPIVX, CLS_OPMVX}) ? OP2_SCALAR : OP2_IMM;
      assert (inst_type == et)
         else stop_run($sformatf("ERR %0t: inst_type_o %0d, expected %0d", $time, inst_type, et));
      assert (!is_arith(cur_cls) || op2_sel == eo)
         else stop_run($sformatf("ERR %0t: op2_sel_o %0d, expected %0d", $time, op2_sel, eo));
      assert (alu_opmode == exp_alu(cur_cls, cur_instr[31:26]))
         else stop_run($sformatf("ERR %0t: alu_opmode_o %0d, expected %0d", $time, alu_opmode,
                                 exp_alu(cur_cls, cur_instr[31:26])));
      assert (vd == cur_instr[11:7] && vector_mask == !cur_instr[25])
         else stop_run($sformatf("ERR %0t: vd_o %0d mask %b for instr %h", $time, vd,
                                 vector_mask, cur_instr));
      assert (alu_x_data == cur_rs1 && alu_imm == cur_instr[19:15])
         else stop_run($sformatf("ERR %0t: x_data %h imm %0d for instr %h", $time, alu_x_data,
                                 alu_imm, cur_instr));
   endtask

   // waits for the start pulse, checks it against the model and records the port
   task automatic wait_start(input int exp_port, input bit immediate, output int port);
      int t;
      bit hz;
      bit rd1;
      bit rd2;
      bit rdd;
      t = 0;
      @(negedge clk);
      while (start == '0)
      begin
         t++;
         if (t > 300)
            stop_run("timeout waiting for start_o");
         @(negedge clk);
      end
      assert ($onehot(start))
         else stop_run($sformatf("ERR %0t: start_o %b is not one-hot", $time, start));
      for (int i = 0; i < WP; i++)
         if (start[i])
            port = i;
      assert (!immediate || t == 0)
         else stop_run($sformatf("ERR %0t: start came %0d cycles late", $time, t));
      assert (exp_port < 0 || port == exp_port)
         else stop_run($sformatf("ERR %0t: start on port %0d, expected %0d", $time, port,
                                 exp_port));
      assert (model_free(port))
         else stop_run($sformatf("ERR %0t: start on busy port %0d", $time, port));
      rd1 = cur_cls inside {CLS_OPIVV, CLS_OPMVV};
      rd2 = is_arith(cur_cls);
      rdd = (cur_cls == CLS_STORE);
      hz  = 1'b0;
      for (int i = 0; i < WP; i++)
         if (!model_free(i) && wr_m[i])
            hz |= (rd1 && vd_m[i] == cur_instr[19:15]) || (rd2 && vd_m[i] == cur_instr[24:20]) ||
                  (rdd && vd_m[i] == cur_instr[11:7]);
      assert (!hz)
         else stop_run($sformatf("ERR %0t: start despite a busy vd match", $time));
      check_decode();
      busy_m[port]  = 1'b1;
      done_m[port]  = 1'b0;
      wr_m[port]    = is_arith(cur_cls) || (cur_cls == CLS_LOAD);
      start_m[port] = cyc;
      vd_m[port]    = cur_instr[11:7];
   endtask

   task automatic expect_stall(input int n);
      repeat (n)
      begin
         @(negedge clk);
         assert (start == '0 && !instr_ready)
            else stop_run($sformatf("ERR %0t: start_o %b ready %b during a stall", $time, start,
                                    instr_ready));
      end
   endtask

   task automatic pulse_done(input port_mask_t m);
      @(posedge clk);
      port_done <= m;
      done_m = done_m | (m & busy_m);
      @(posedge clk);
      port_done <= '0;
   endtask

   task automatic release_all();
      pulse_done(busy_m);
      repeat (`VCU_DEP_DELAY + 4) @(posedge clk);  // past the dependency window
      busy_m = '0;
      done_m = '0;
   endtask

   task automatic check_reset();
      @(negedge clk);
      assert (instr_ready && start == '0)
         else stop_run($sformatf("ERR %0t: ready %b start %b after reset", $time, instr_ready,
                                 start));
      assert (vl == `VCU_VLEN / 32 && sew == 3'd2 && lmul == 3'd0)
         else stop_run($sformatf("ERR %0t: vl %0d sew %0d lmul %0d after reset", $time, vl, sew,
                                 lmul));
      exp_vl = `VCU_VLEN / 32;
   endtask

   task automatic check_config();
      sew_t        s;
      lmul_t       l;
      logic [31:0] r;
      vreg_t       f1;
      vreg_t       fd;
      for (int k = 0; k < 12; k++)
      begin
         s  = sew_t'($urandom_range(3));
         l  = lmul_t'($urandom_range(6));
         l  = (l >= 3'd4) ? l + 3'd1 : l;  // skip reserved code 4
         r  = $urandom_range(255, 1);
         f1 = (k % 3 == 0) ? vreg_t'($urandom_range(31, 1)) : 5'd0;
         fd = (k % 3 == 2) ? 5'd0 : vreg_t'($urandom_range(31, 1));
         drive_instr(CLS_CONFIG, make_vsetvli(s, l, f1, fd), r);
         if (k % 3 == 0)
            exp_vl = r;
         else if (k % 3 == 1)
            exp_vl = exp_vlmax(l, s);
         @(negedge clk);
         assert (sew == s && lmul == l)
            else stop_run($sformatf("ERR %0t: sew %0d lmul %0d, expected %0d %0d", $time, sew,
                                    lmul, s, l));
         assert (vl == exp_vl)
            else stop_run($sformatf("ERR %0t: vl_o %0d, expected %0d", $time, vl, exp_vl));
         assert (instr_ready)
            else stop_run("instr_ready_o went low after a config instruction");
      end
   endtask

   task automatic check_decode_table();
      logic [5:0]   codes [11];
      instr_class_e cls [5];
      logic [31:0]  ins;
      int           p;
      codes = '{6'h00, 6'h02, 6'h09, 6'h0a, 6'h0b, 6'h25, 6'h28, 6'h29, 6'h27, 6'h2d, 6'h3f};
      cls   = '{CLS_OPIVV, CLS_OPIVX, CLS_OPIVI, CLS_OPMVV, CLS_OPMVX};
      foreach (cls[c])
         foreach (codes[i])
         begin
            ins = make_instr(codes[i], 1'($urandom_range(1)), vreg_t'($urandom_range(31)),
                             vreg_t'($urandom_range(31)), vreg_t'($urandom_range(31)), OPC_V);
            drive_instr(cls[c], ins, $urandom);
            wait_start(-1, 1'b0, p);
            pulse_done(port_mask_t'(1 << p));
         end
      drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd0, 5'd3, 5'd17, OPC_LD), $urandom);
      wait_start(-1, 1'b0, p);
      pulse_done(port_mask_t'(1 << p));
      drive_instr(CLS_STORE, make_instr(6'h00, 1'b0, 5'd0, 5'd3, 5'd18, OPC_ST), $urandom);
      wait_start(-1, 1'b0, p);
      release_all();
   endtask

   task automatic check_alloc();
      int p;
      for (int k = 0; k < WP; k++)
      begin
         drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd0, 5'd0, vreg_t'(k + 1), OPC_LD), k);
         wait_start(k, 1'b1, p);
      end
      drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd0, 5'd0, 5'd20, OPC_LD), 32'd9);
      expect_stall(20);  // timers run out, no done yet
      pulse_done(port_mask_t'((1 << (WP - 1)) | 2));  // two ports finish together
      wait_start(1, 1'b0, p);
      release_all();
   endtask

   task automatic check_hazards();
      int p;
      drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd0, 5'd0, 5'd5, OPC_LD), 32'd0);
      wait_start(0, 1'b1, p);
      drive_instr(CLS_OPIVV, make_instr(6'h00, 1'b1, 5'd7, 5'd5, 5'd9, OPC_V), 32'd1);
      expect_stall(15);
      pulse_done(port_mask_t'(1));
      wait_start(0, 1'b0, p);
      drive_instr(CLS_OPIVI, make_instr(6'h02, 1'b1, 5'd9, 5'd3, 5'd11, OPC_V), 32'd2);
      expect_stall(15);
      pulse_done(port_mask_t'(1));
      wait_start(0, 1'b0, p);
      drive_instr(CLS_STORE, make_instr(6'h00, 1'b1, 5'd0, 5'd0, 5'd11, OPC_ST), 32'd3);
      expect_stall(15);
      pulse_done(port_mask_t'(1));
      wait_start(0, 1'b0, p);
      // port 0 holds a store now
      drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd0, 5'd0, 5'd12, OPC_LD), 32'd4);
      wait_start(1, 1'b1, p);
      drive_instr(CLS_LOAD, make_instr(6'h00, 1'b1, 5'd12, 5'd12, 5'd12, OPC_LD), 32'd5);
      wait_start(2, 1'b1, p);
      drive_instr(CLS_OPIVX, make_instr(6'h00, 1'b1, 5'd4, 5'd12, 5'd6, OPC_V), 32'd6);
      wait_start(3, 1'b1, p);  // vs1 field is a scalar here
      release_all();
   endtask

   initial
   begin
      clk         = 1'b0;
      rstn        = 1'b0;
      instr_valid = 1'b0;
      instr_class = CLS_CONFIG;
      instr       = '0;
      scalar_rs1  = '0;
      port_done   = '0;
      cyc         = 0;
      busy_m      = '0;
      done_m      = '0;
      wr_m        = '0;
      void'($urandom(84170));
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      check_reset();
      check_config();
      check_decode_table();
      check_alloc();
      check_hazards();
      $display("Done: no errors");
      $finish;
   end

   initial
   begin
      #500000;
      stop_run("simulation watchdog expired before the tests finished");
   end
endmodule

/* vector_cu.f */
+incdir+common
common/vcu_cfg_pkg.sv
common/vcu_op_pkg.sv
common/decode_if.sv
config/vtype_config.sv
decode/instr_decoder.sv
issue/dep_timer.sv
issue/port_tracker.sv
issue/issue_fsm.sv
source/vector_cu.sv
tests/vector_cu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vector_cu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vector_cu.f \
   --top-module vector_cu_tb -o vector_cu_sim
./obj_dir/vector_cu_sim | tee sim.log
if grep -q "^Done: no errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
